// File: Bender.yml
package:
  name: acc_dispatcher

sources:
  - files:
      - hdl/acc_disp_pkg.sv
      - hdl/acc_insn_queue.sv
      - hdl/acc_spec_tracker.sv
      - hdl/acc_mem_tracker.sv
      - hdl/acc_dispatcher.sv
  - target: test
    files:
      - bench/acc_dispatcher_checker.sv
      - bench/acc_dispatcher_tb.sv

// File: bench/acc_dispatcher_checker.sv
// Bound assertions for counter wrap, request stability under back-pressure and barrier release
`timescale 1ns/100ps

module acc_dispatcher_checker (
  input logic                                   clk_i,
  input logic                                   reset_i,
  input logic                                   mem_overflow_i,
  input logic                                   req_valid_i,
  input logic                                   req_ready_i,
  input logic [31:0]                            req_insn_i,
  input logic [acc_disp_pkg::XLEN-1:0]          req_rs1_i,
  input logic [acc_disp_pkg::XLEN-1:0]          req_rs2_i,
  input logic [2:0]                             req_frm_i,
  input logic [acc_disp_pkg::TRANS_ID_BITS-1:0] req_trans_id_i,
  input logic                                   halt_i,
  input logic                                   store_pending_i
);

  // Load/store counters never wrap
  a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i) !mem_overflow_i)
    else $error("memory counter wrapped");

  // A stalled request keeps valid and all its fields
  a_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_insn_i) &&
      $stable(req_rs1_i) && $stable(req_rs2_i) && $stable(req_frm_i) &&
      $stable(req_trans_id_i))
    else $error("request changed while stalled");

  // Halt drops one cycle after stores drain
  a_halt_release: assert property (@(posedge clk_i) disable iff (reset_i)
    !store_pending_i |=> !halt_i)
    else $error("halt still high after store pending cleared");

endmodule

bind acc_dispatcher acc_dispatcher_checker u_checker (
  .clk_i           (clk_i),
  .reset_i         (reset_i),
  .mem_overflow_i  (mem_overflow_o),
  .req_valid_i     (acc_req_valid_o),
  .req_ready_i     (acc_req_ready_i),
  .req_insn_i      (acc_req_insn_o),
  .req_rs1_i       (acc_req_rs1_o),
  .req_rs2_i       (acc_req_rs2_o),
  .req_frm_i       (acc_req_frm_o),
  .req_trans_id_i  (acc_req_trans_id_o),
  .halt_i          (ctrl_halt_o),
  .store_pending_i (acc_resp_store_pending_i)
);

// File: bench/acc_dispatcher_tb.sv
// Dispatcher testbench with clock, accelerator model, reference function, monitor and summary
`timescale 1ns/100ps

module acc_dispatcher_tb;

  localparam int unsigned MAX_CYCLES = 4000;

  logic clk_i, reset_i, acc_cons_en_i;
  logic [2:0] fcsr_frm_i;
  logic issue_hs_i, issue_executed_i, flush_unissued_i, flush_ex_i;
  acc_disp_pkg::fu_e issue_fu_i;
  acc_disp_pkg::acc_op_e issue_op_i;
  logic issue_stall_o, acc_valid_ex_o;
  logic [31:0] fu_insn_i;
  logic [acc_disp_pkg::XLEN-1:0] fu_rs1_i, fu_rs2_i;
  logic [acc_disp_pkg::TRANS_ID_BITS-1:0] fu_trans_id_i;
  logic [1:0] commit_issued_i, commit_ack_i;
  acc_disp_pkg::fu_e [1:0] commit_fu_i;
  logic [1:0][acc_disp_pkg::TRANS_ID_BITS-1:0] commit_trans_id_i;
  logic commit_st_barrier_i, no_st_pending_i, dirty_v_state_o, ctrl_halt_o;
  logic acc_req_valid_o, acc_req_store_pending_o, acc_req_cons_en_o, acc_req_ready_i;
  logic [31:0] acc_req_insn_o;
  logic [acc_disp_pkg::XLEN-1:0] acc_req_rs1_o, acc_req_rs2_o, acc_resp_result_i, acc_result_o;
  logic [2:0] acc_req_frm_o;
  logic [acc_disp_pkg::TRANS_ID_BITS-1:0] acc_req_trans_id_o, acc_resp_trans_id_i, acc_trans_id_o;
  logic acc_resp_valid_i, acc_resp_error_i, acc_resp_store_pending_i;
  logic acc_resp_load_complete_i, acc_resp_store_complete_i;
  logic acc_valid_o, acc_exception_valid_o, mem_overflow_o;

  // Bench state: issued but uncommitted, and committed but not yet requested
  acc_disp_pkg::acc_insn_t issued_q[$];
  acc_disp_pkg::acc_insn_t expect_q[$];
  int errors = 0;
  int cycles = 0;
  int ld_out = 0, st_out = 0;
  int ld_owed = 0, st_owed = 0;
  logic hold_ready = 1'b0, hold_ld = 1'b0, hold_st = 1'b0;
  logic [2:0] next_id = '0;
  string test_name = "reset";

  acc_dispatcher UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles in test %s", cycles, test_name);
      $display("Test failures found");
      $finish;
    end
  end

  // Expected request from a committed entry and the rounding mode at request time
  function automatic acc_disp_pkg::acc_req_t expected_req(input acc_disp_pkg::acc_insn_t e,
                                                          input logic [2:0] frm);
    acc_disp_pkg::acc_req_t r;
    r.insn     = e.insn;
    r.rs1      = e.rs1;
    r.rs2      = e.rs2;
    r.frm      = frm;
    r.trans_id = e.trans_id;
    return r;
  endfunction

  // Compare every accepted request with the head of the committed entries
  always @(negedge clk_i) begin
    acc_disp_pkg::acc_req_t exp_r, act_r;
    acc_disp_pkg::acc_insn_t head;
    if (!reset_i && acc_req_valid_o && acc_req_ready_i) begin
      act_r = '{insn: acc_req_insn_o, rs1: acc_req_rs1_o, rs2: acc_req_rs2_o,
                frm: acc_req_frm_o, trans_id: acc_req_trans_id_o};
      if (expect_q.size() == 0) begin
        errors++;
        $display("Request for ID %0d was sent before any commit allowed it", act_r.trans_id);
      end else begin
        head  = expect_q.pop_front();
        exp_r = expected_req(head, fcsr_frm_i);
        assert (act_r == exp_r) else begin
          errors++;
          $display("Error %s: expected %h, actual %h", test_name, exp_r, act_r);
        end
        if (head.op == acc_disp_pkg::ACCEL_OP_LOAD)
          ld_owed++;
        if (head.op == acc_disp_pkg::ACCEL_OP_STORE)
          st_owed++;
      end
    end
  end

  // Accelerator model: random ready and delayed completions
  always @(posedge clk_i) begin
    #1;
    acc_req_ready_i = !hold_ready && ($urandom % 4 != 0);
    acc_resp_load_complete_i  = !hold_ld && ld_owed > 0 && ($urandom % 2 == 0);
    acc_resp_store_complete_i = !hold_st && st_owed > 0 && ($urandom % 2 == 0);
    if (acc_resp_load_complete_i) begin
      ld_owed--;
      ld_out--;
    end
    if (acc_resp_store_complete_i) begin
      st_owed--;
      st_out--;
    end
  end

  task automatic issue_accel(input acc_disp_pkg::acc_op_e op);
    acc_disp_pkg::acc_insn_t e;
    issue_fu_i = acc_disp_pkg::ACCEL;
    issue_op_i = op;
    @(negedge clk_i);
    // Respect the issue stall before the handshake
    while (issue_stall_o)
      @(negedge clk_i);
    @(posedge clk_i);
    #1;
    issue_hs_i = 1'b1;
    if (op == acc_disp_pkg::ACCEL_OP_LOAD)
      ld_out++;
    if (op == acc_disp_pkg::ACCEL_OP_STORE)
      st_out++;
    @(posedge clk_i);
    #1;
    issue_hs_i = 1'b0;
    issue_fu_i = acc_disp_pkg::NONE;
    // Accepted entry is in execute for exactly this cycle
    check_bit({test_name, " valid ex"}, 1'b1, acc_valid_ex_o);
    e = '{insn: $urandom, rs1: {$urandom, $urandom}, rs2: {$urandom, $urandom},
          op: op, trans_id: next_id};
    fu_insn_i     = e.insn;
    fu_rs1_i      = e.rs1;
    fu_rs2_i      = e.rs2;
    fu_trans_id_i = e.trans_id;
    issued_q.push_back(e);
    next_id++;
    @(posedge clk_i);
    #1;
    check_bit({test_name, " valid ex end"}, 1'b0, acc_valid_ex_o);
  endtask

  // Handshake that the dispatcher has to ignore
  task automatic issue_rejected(input logic executed, input logic unissued_flush);
    issue_fu_i       = acc_disp_pkg::ACCEL;
    issue_hs_i       = 1'b1;
    issue_executed_i = executed;
    flush_unissued_i = unissued_flush;
    @(posedge clk_i);
    #1;
    issue_hs_i       = 1'b0;
    issue_fu_i       = acc_disp_pkg::NONE;
    issue_executed_i = 1'b0;
    flush_unissued_i = 1'b0;
    check_bit({test_name, " rejected issue"}, 1'b0, acc_valid_ex_o);
  endtask

  // Commit the oldest issued entry on port 0
  task automatic commit_oldest();
    acc_disp_pkg::acc_insn_t e;
    e = issued_q.pop_front();
    expect_q.push_back(e);
    commit_issued_i      = 2'b10;
    commit_fu_i[0]       = acc_disp_pkg::ACCEL;
    commit_trans_id_i[0] = e.trans_id;
    commit_ack_i         = 2'b01;
    @(posedge clk_i);
    #1;
    commit_issued_i = 2'b11;
    commit_fu_i[0]  = acc_disp_pkg::NONE;
    commit_fu_i[1]  = acc_disp_pkg::NONE;
    commit_ack_i    = 2'b00;
  endtask

  task automatic wait_drained();
    while (expect_q.size() != 0 || ld_out != 0 || st_out != 0)
      @(posedge clk_i);
    repeat (2) @(posedge clk_i);
    #1;
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    assert (exp_v === act_v) else begin
      errors++;
      $display("Error %s: expected %0b, actual %0b", name, exp_v, act_v);
    end
  endtask

  // Scalar stall expected from the bench's own outstanding counts
  task automatic check_scalar_stalls();
    issue_fu_i = acc_disp_pkg::LOAD;
    #1;
    check_bit({test_name, " load"}, acc_cons_en_i && st_out > 0, issue_stall_o);
    issue_fu_i = acc_disp_pkg::STORE;
    #1;
    check_bit({test_name, " store"}, acc_cons_en_i && (st_out > 0 || ld_out > 0), issue_stall_o);
    issue_fu_i = acc_disp_pkg::NONE;
    // Mode and scalar store pending as forwarded to the accelerator
    check_bit({test_name, " cons en"}, acc_cons_en_i, acc_req_cons_en_o);
    check_bit({test_name, " no scalar store"}, 1'b0, acc_req_store_pending_o);
    no_st_pending_i = 1'b0;
    #1;
    check_bit({test_name, " scalar store"}, acc_cons_en_i, acc_req_store_pending_o);
    no_st_pending_i = 1'b1;
  endtask

  initial begin
    void'($urandom(32'had6e));
    reset_i = 1'b1;
    acc_cons_en_i = 1'b0;
    fcsr_frm_i = 3'd1;
    issue_hs_i = 1'b0;
    issue_fu_i = acc_disp_pkg::NONE;
    issue_op_i = acc_disp_pkg::ACCEL_OP;
    issue_executed_i = 1'b0;
    flush_unissued_i = 1'b0;
    flush_ex_i = 1'b0;
    fu_insn_i = '0;
    fu_rs1_i = '0;
    fu_rs2_i = '0;
    fu_trans_id_i = '0;
    commit_issued_i = 2'b11;
    commit_fu_i[0] = acc_disp_pkg::NONE;
    commit_fu_i[1] = acc_disp_pkg::NONE;
    commit_trans_id_i = '0;
    commit_ack_i = 2'b00;
    commit_st_barrier_i = 1'b0;
    no_st_pending_i = 1'b1;
    acc_req_ready_i = 1'b0;
    acc_resp_valid_i = 1'b0;
    acc_resp_trans_id_i = '0;
    acc_resp_result_i = '0;
    acc_resp_error_i = 1'b0;
    acc_resp_store_pending_i = 1'b0;
    acc_resp_load_complete_i = 1'b0;
    acc_resp_store_complete_i = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    check_bit("reset halt", 1'b0, ctrl_halt_o);
    check_bit("reset req valid", 1'b0, acc_req_valid_o);

    test_name = "dispatch";
    for (int n = 0; n < 16; n++) begin
      issue_accel(acc_disp_pkg::acc_op_e'($urandom_range(0, 2)));
      repeat ($urandom_range(0, 5)) @(posedge clk_i);
      #1;
      commit_oldest();
    end
    wait_drained();

    test_name = "flush";
    fcsr_frm_i = 3'd4;
    // Executed entries and flushed issue never reach execute
    issue_rejected(1'b1, 1'b0);
    issue_rejected(1'b0, 1'b1);
    issue_accel(acc_disp_pkg::ACCEL_OP);
    issue_accel(acc_disp_pkg::ACCEL_OP);
    flush_ex_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_ex_i = 1'b0;
    issued_q.delete();
    for (int n = 0; n < 3; n++) begin
      issue_accel(acc_disp_pkg::ACCEL_OP);
      commit_oldest();
    end
    wait_drained();

    test_name = "backpressure";
    hold_ready = 1'b1;
    @(posedge clk_i);
    #1;
    for (int n = 0; n < 3; n++) begin
      issue_accel(acc_disp_pkg::ACCEL_OP);
      commit_oldest();
    end
    // Request register holds one, the queue holds two
    issue_fu_i = acc_disp_pkg::ACCEL;
    repeat (3) @(posedge clk_i);
    #1;
    check_bit("backpressure stall", 1'b1, issue_stall_o);
    issue_fu_i = acc_disp_pkg::NONE;
    hold_ready = 1'b0;
    wait_drained();

    test_name = "consistency";
    acc_cons_en_i = 1'b1;
    hold_st = 1'b1;
    issue_accel(acc_disp_pkg::ACCEL_OP_STORE);
    commit_oldest();
    while (st_owed == 0)
      @(posedge clk_i);
    repeat (2) @(posedge clk_i);
    #1;
    check_scalar_stalls();
    hold_st = 1'b0;
    wait_drained();
    hold_ld = 1'b1;
    issue_accel(acc_disp_pkg::ACCEL_OP_LOAD);
    commit_oldest();
    while (ld_owed == 0)
      @(posedge clk_i);
    repeat (2) @(posedge clk_i);
    #1;
    check_scalar_stalls();
    acc_cons_en_i = 1'b0;
    check_scalar_stalls();
    hold_ld = 1'b0;
    wait_drained();

    test_name = "barrier";
    acc_resp_store_pending_i = 1'b1;
    commit_st_barrier_i = 1'b1;
    @(posedge clk_i);
    #1;
    commit_st_barrier_i = 1'b0;
    check_bit("barrier rise", 1'b1, ctrl_halt_o);
    @(posedge clk_i);
    #1;
    check_bit("barrier hold", 1'b1, ctrl_halt_o);
    acc_resp_store_pending_i = 1'b0;
    @(posedge clk_i);
    #1;
    check_bit("barrier fall", 1'b0, ctrl_halt_o);

    test_name = "response";
    for (int n = 0; n < 20; n++) begin
      logic exp_dirty;
      acc_resp_valid_i    = 1'($urandom);
      acc_resp_trans_id_i = 3'($urandom);
      acc_resp_result_i   = {$urandom, $urandom};
      acc_resp_error_i    = 1'($urandom);
      commit_ack_i        = 2'($urandom);
      commit_fu_i[0]      = acc_disp_pkg::fu_e'($urandom_range(0, 4));
      commit_fu_i[1]      = acc_disp_pkg::fu_e'($urandom_range(0, 4));
      @(negedge clk_i);
      exp_dirty = 1'b0;
      for (int p = 0; p < 2; p++)
        exp_dirty |= commit_ack_i[p] && commit_fu_i[p] == acc_disp_pkg::ACCEL;
      check_bit("response valid", acc_resp_valid_i, acc_valid_o);
      check_bit("response error", acc_resp_error_i, acc_exception_valid_o);
      check_bit("dirty v", exp_dirty, dirty_v_state_o);
      assert (acc_result_o == acc_resp_result_i && acc_trans_id_o == acc_resp_trans_id_i)
        else begin
          errors++;
          $display("Error %s: expected %h/%0d, actual %h/%0d", test_name, acc_resp_result_i,
                   acc_resp_trans_id_i, acc_result_o, acc_trans_id_o);
        end
      @(posedge clk_i);
      #1;
    end
    commit_ack_i   = 2'b00;
    commit_fu_i[0] = acc_disp_pkg::NONE;
    commit_fu_i[1] = acc_disp_pkg::NONE;
    repeat (4) @(posedge clk_i);

    $display("Errors: %0d, undelivered requests: %0d", errors, expect_q.size());
    if (errors == 0 && expect_q.size() == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: compile.f
hdl/acc_disp_pkg.sv
hdl/acc_insn_queue.sv
hdl/acc_spec_tracker.sv
hdl/acc_mem_tracker.sv
hdl/acc_dispatcher.sv
bench/acc_dispatcher_checker.sv
bench/acc_dispatcher_tb.sv

// File: hdl/acc_disp_pkg.sv
// Dispatcher widths, depths, unit and operation codes, queue and request payload types
package acc_disp_pkg;

  // Scoreboard transaction IDs and tracking bitmap width
  localparam int unsigned TRANS_ID_BITS = 3;
  localparam int unsigned NR_SB_ENTRIES = 8;

  // Commit ports of the in-order core
  localparam int unsigned NR_COMMIT_PORTS = 2;

  // Operand and result width
  localparam int unsigned XLEN = 64;

  // Instruction queue depth
  localparam int unsigned INSN_QUEUE_DEPTH = 3;

  // Width of the in-flight load/store counters
  localparam int unsigned MEM_CNT_BITS = 3;

  // Functional unit selected by the decoder
  typedef enum logic [2:0] {
    NONE,
    LOAD,
    STORE,
    ALU,
    ACCEL
  } fu_e;

  // Accelerator operation class, memory classes feed the trackers
  typedef enum logic [1:0] {
    ACCEL_OP,
    ACCEL_OP_LOAD,
    ACCEL_OP_STORE
  } acc_op_e;

  // Entry held in the instruction queue
  typedef struct packed {
    logic [31:0]              insn;
    logic [XLEN-1:0]          rs1;
    logic [XLEN-1:0]          rs2;
    acc_op_e                  op;
    logic [TRANS_ID_BITS-1:0] trans_id;
  } acc_insn_t;

  // Request as seen by the accelerator
  typedef struct packed {
    logic [31:0]              insn;
    logic [XLEN-1:0]          rs1;
    logic [XLEN-1:0]          rs2;
    logic [2:0]               frm;
    logic [TRANS_ID_BITS-1:0] trans_id;
  } acc_req_t;

endpackage

// File: hdl/acc_dispatcher.sv
// Accelerator dispatcher top with issue register, stall decode, request path, response and barrier
`timescale 1ns/100ps

module acc_dispatcher (
  input  logic                                                clk_i,
  input  logic                                                reset_i,
  input  logic                                                acc_cons_en_i,
  input  logic [2:0]                                          fcsr_frm_i,
  // Issue stage
  input  logic                                                issue_hs_i,
  input  acc_disp_pkg::fu_e                                   issue_fu_i,
  input  acc_disp_pkg::acc_op_e                               issue_op_i,
  input  logic                                                issue_executed_i,
  input  logic                                                flush_unissued_i,
  input  logic                                                flush_ex_i,
  output logic                                                issue_stall_o,
  output logic                                                acc_valid_ex_o,
  // Execute stage operands, one cycle after issue
  input  logic [31:0]                                         fu_insn_i,
  input  logic [acc_disp_pkg::XLEN-1:0]                       fu_rs1_i,
  input  logic [acc_disp_pkg::XLEN-1:0]                       fu_rs2_i,
  input  logic [acc_disp_pkg::TRANS_ID_BITS-1:0]              fu_trans_id_i,
  // Commit stage
  input  logic [acc_disp_pkg::NR_COMMIT_PORTS-1:0]            commit_issued_i,
  input  acc_disp_pkg::fu_e [acc_disp_pkg::NR_COMMIT_PORTS-1:0] commit_fu_i,
  input  logic [acc_disp_pkg::NR_COMMIT_PORTS-1:0][acc_disp_pkg::TRANS_ID_BITS-1:0]
                                                              commit_trans_id_i,
  input  logic [acc_disp_pkg::NR_COMMIT_PORTS-1:0]            commit_ack_i,
  input  logic                                                commit_st_barrier_i,
  input  logic                                                no_st_pending_i,
  output logic                                                dirty_v_state_o,
  output logic                                                ctrl_halt_o,
  // Accelerator request
  output logic                                                acc_req_valid_o,
  output logic [31:0]                                         acc_req_insn_o,
  output logic [acc_disp_pkg::XLEN-1:0]                       acc_req_rs1_o,
  output logic [acc_disp_pkg::XLEN-1:0]                       acc_req_rs2_o,
  output logic [2:0]                                          acc_req_frm_o,
  output logic [acc_disp_pkg::TRANS_ID_BITS-1:0]              acc_req_trans_id_o,
  output logic                                                acc_req_store_pending_o,
  output logic                                                acc_req_cons_en_o,
  input  logic                                                acc_req_ready_i,
  // Accelerator response
  input  logic                                                acc_resp_valid_i,
  input  logic [acc_disp_pkg::TRANS_ID_BITS-1:0]              acc_resp_trans_id_i,
  input  logic [acc_disp_pkg::XLEN-1:0]                       acc_resp_result_i,
  input  logic                                                acc_resp_error_i,
  input  logic                                                acc_resp_store_pending_i,
  input  logic                                                acc_resp_load_complete_i,
  input  logic                                                acc_resp_store_complete_i,
  // Writeback to the core
  output logic                                                acc_valid_o,
  output logic [acc_disp_pkg::TRANS_ID_BITS-1:0]              acc_trans_id_o,
  output logic [acc_disp_pkg::XLEN-1:0]                       acc_result_o,
  output logic                                                acc_exception_valid_o,
  output logic                                                mem_overflow_o
);

  logic                                                acc_valid_d, acc_valid_q;
  acc_disp_pkg::acc_op_e                               acc_op_q;
  logic                                                insn_push;
  logic                                                insn_pop;
  logic                                                insn_empty;
  logic [$clog2(acc_disp_pkg::INSN_QUEUE_DEPTH+1)-1:0] insn_usage;
  acc_disp_pkg::acc_insn_t                             insn_in, insn_head;
  acc_disp_pkg::acc_req_t                              req_in, req_out;
  logic                                                req_valid;
  logic                                                req_full;
  logic                                                req_empty;
  logic                                                query_ok;
  logic                                                no_ld_pending, no_st_pending;
  logic                                                wait_st_q;

  // Accept an unexecuted ACCEL entry unless unissued work is being flushed
  assign acc_valid_d = issue_hs_i && issue_fu_i == acc_disp_pkg::ACCEL &&
                       !issue_executed_i && !flush_unissued_i;

  always_ff @(posedge clk_i) begin
    if (reset_i)
      acc_valid_q <= 1'b0;
    else
      acc_valid_q <= acc_valid_d;
  end

  // Operation class waits for the operands of the next cycle
  always_ff @(posedge clk_i) begin
    if (acc_valid_d)
      acc_op_q <= issue_op_i;
  end

  assign acc_valid_ex_o = acc_valid_q;

  always_comb begin
    case (issue_fu_i)
      // Keep one slot free for the entry already in execute
      acc_disp_pkg::ACCEL: issue_stall_o = insn_usage >= (acc_disp_pkg::INSN_QUEUE_DEPTH - 1);
      // Scalar load behind an accelerator store
      acc_disp_pkg::LOAD:  issue_stall_o = acc_cons_en_i && !no_st_pending;
      // Scalar store behind any accelerator memory access
      acc_disp_pkg::STORE: issue_stall_o = acc_cons_en_i && (!no_st_pending || !no_ld_pending);
      default:             issue_stall_o = 1'b0;
    endcase
  end

  assign insn_in = '{insn: fu_insn_i, rs1: fu_rs1_i, rs2: fu_rs2_i,
                     op: acc_op_q, trans_id: fu_trans_id_i};
  // An entry flushed on arrival never enters the queue
  assign insn_push = acc_valid_q && !flush_ex_i;

  acc_insn_queue #(
    .dtype (acc_disp_pkg::acc_insn_t),
    .DEPTH (acc_disp_pkg::INSN_QUEUE_DEPTH)
  ) i_insn_queue (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .flush_i (flush_ex_i),
    .push_i  (insn_push),
    .data_i  (insn_in),
    .pop_i   (insn_pop),
    .data_o  (insn_head),
    .empty_o (insn_empty),
    .full_o  (),
    .usage_o (insn_usage)
  );

  acc_spec_tracker i_spec_tracker (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .flush_i             (flush_ex_i),
    .recv_valid_i        (insn_push),
    .recv_trans_id_i     (fu_trans_id_i),
    .commit_issued_i     (commit_issued_i),
    .commit_fu_i         (commit_fu_i),
    .commit_trans_id_i   (commit_trans_id_i),
    .dispatch_i          (insn_pop),
    .dispatch_trans_id_i (insn_head.trans_id),
    .query_trans_id_i    (insn_head.trans_id),
    .query_ok_o          (query_ok)
  );

  // Rounding mode is current when the head is offered
  assign req_in = '{insn: insn_head.insn, rs1: insn_head.rs1, rs2: insn_head.rs2,
                    frm: fcsr_frm_i, trans_id: insn_head.trans_id};
  // Head leaves only once it is no longer speculative
  assign req_valid = !insn_empty && query_ok;
  assign insn_pop  = req_valid && !req_full;

  // Single-entry fall-through register holds the request under back-pressure
  acc_insn_queue #(
    .dtype (acc_disp_pkg::acc_req_t),
    .DEPTH (1)
  ) i_req_reg (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .flush_i (1'b0),
    .push_i  (req_valid),
    .data_i  (req_in),
    .pop_i   (acc_req_valid_o && acc_req_ready_i),
    .data_o  (req_out),
    .empty_o (req_empty),
    .full_o  (req_full),
    .usage_o ()
  );

  assign acc_req_valid_o         = !req_empty;
  assign acc_req_insn_o          = req_out.insn;
  assign acc_req_rs1_o           = req_out.rs1;
  assign acc_req_rs2_o           = req_out.rs2;
  assign acc_req_frm_o           = req_out.frm;
  assign acc_req_trans_id_o      = req_out.trans_id;
  assign acc_req_store_pending_o = acc_cons_en_i && !no_st_pending_i;
  assign acc_req_cons_en_o       = acc_cons_en_i;

  acc_mem_tracker i_mem_tracker (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .flush_i         (flush_ex_i),
    .spec_ld_i       (acc_valid_d && issue_op_i == acc_disp_pkg::ACCEL_OP_LOAD),
    .spec_st_i       (acc_valid_d && issue_op_i == acc_disp_pkg::ACCEL_OP_STORE),
    .disp_ld_i       (insn_pop && insn_head.op == acc_disp_pkg::ACCEL_OP_LOAD),
    .disp_st_i       (insn_pop && insn_head.op == acc_disp_pkg::ACCEL_OP_STORE),
    .ld_complete_i   (acc_resp_load_complete_i),
    .st_complete_i   (acc_resp_store_complete_i),
    .no_ld_pending_o (no_ld_pending),
    .no_st_pending_o (no_st_pending),
    .overflow_o      (mem_overflow_o)
  );

  // Responses are always taken, error maps to illegal instruction
  assign acc_valid_o           = acc_resp_valid_i;
  assign acc_trans_id_o        = acc_resp_trans_id_i;
  assign acc_result_o          = acc_resp_result_i;
  assign acc_exception_valid_o = acc_resp_error_i;

  // Any acknowledged ACCEL commit touches vector state
  always_comb begin
    dirty_v_state_o = 1'b0;
    for (int i = 0; i < acc_disp_pkg::NR_COMMIT_PORTS; i++) begin
      dirty_v_state_o |= commit_ack_i[i] && commit_fu_i[i] == acc_disp_pkg::ACCEL;
    end
  end

  // Halt after a store barrier while accelerator stores drain
  always_ff @(posedge clk_i) begin
    if (reset_i)
      wait_st_q <= 1'b0;
    else
      wait_st_q <= (wait_st_q || commit_st_barrier_i) && acc_resp_store_pending_i;
  end

  assign ctrl_halt_o = wait_st_q;

endmodule

// File: hdl/acc_insn_queue.sv
// Fall-through FIFO with type parameter, flush and usage count
`timescale 1ns/100ps

module acc_insn_queue #(
  parameter type         dtype = logic,
  parameter int unsigned DEPTH = 3
) (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         flush_i,
  input  logic                         push_i,
  input  dtype                         data_i,
  input  logic                         pop_i,
  output dtype                         data_o,
  output logic                         empty_o,
  output logic                         full_o,
  output logic [$clog2(DEPTH+1)-1:0]   usage_o
);

  // Pointer needs at least one bit even for a single entry
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  dtype                       mem_q [DEPTH];
  logic [PTR_W-1:0]           rd_ptr_q;
  logic [PTR_W-1:0]           wr_ptr_q;
  logic [$clog2(DEPTH+1)-1:0] cnt_q;
  logic                       do_push;
  logic                       do_pop;
  logic                       bypass;

  // Wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (cnt_q == DEPTH);
  assign usage_o = cnt_q;
  // A push into an empty buffer is visible at once
  assign empty_o = (cnt_q == '0) && !push_i;
  assign data_o  = (cnt_q == '0) ? data_i : mem_q[rd_ptr_q];

  // Empty buffer, push and pop together: data passes straight through
  assign bypass  = (cnt_q == '0) && push_i && pop_i;
  assign do_push = push_i && !full_o && !bypass;
  assign do_pop  = pop_i && (cnt_q != '0);

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // Occupancy moves only when push and pop do not cancel
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: hdl/acc_mem_tracker.sv
// Speculative and dispatched accelerator load/store counters with no-pending flags
`timescale 1ns/100ps

module acc_mem_tracker (
  input  logic clk_i,
  input  logic reset_i,
  input  logic flush_i,
  input  logic spec_ld_i,
  input  logic spec_st_i,
  input  logic disp_ld_i,
  input  logic disp_st_i,
  input  logic ld_complete_i,
  input  logic st_complete_i,
  output logic no_ld_pending_o,
  output logic no_st_pending_o,
  output logic overflow_o
);

  // Counter order: spec loads, spec stores, dispatched loads, dispatched stores
  logic [3:0][acc_disp_pkg::MEM_CNT_BITS-1:0] cnt_q;
  logic [3:0]                                 inc;
  logic [3:0]                                 dec;
  logic [3:0]                                 clr;
  logic [3:0]                                 wrap;

  assign inc = {disp_st_i, disp_ld_i, spec_st_i, spec_ld_i};
  // Dispatch moves an entry from speculative to dispatched
  assign dec = {st_complete_i, ld_complete_i, disp_st_i, disp_ld_i};
  // Dispatched entries can no longer be flushed
  assign clr = {2'b00, flush_i, flush_i};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (clr[i])
          cnt_q[i] <= '0;
        else if (inc[i] && !dec[i])
          cnt_q[i] <= cnt_q[i] + 1'b1;
        else if (dec[i] && !inc[i])
          cnt_q[i] <= cnt_q[i] - 1'b1;
      end
    end
  end

  // Up at all ones or down at zero would wrap
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      wrap[i] = !clr[i] &&
                ((inc[i] && !dec[i] && cnt_q[i] == '1) ||
                 (dec[i] && !inc[i] && cnt_q[i] == '0));
    end
  end

  assign overflow_o = |wrap;

  // A class is idle once both its counters are empty
  assign no_ld_pending_o = (cnt_q[0] == '0) && (cnt_q[2] == '0);
  assign no_st_pending_o = (cnt_q[1] == '0) && (cnt_q[3] == '0);

endmodule

// File: hdl/acc_spec_tracker.sv
// Pending and ready bitmaps per transaction ID with commit-port release decode
`timescale 1ns/100ps

module acc_spec_tracker (
  input  logic                                                              clk_i,
  input  logic                                                              reset_i,
  input  logic                                                              flush_i,
  input  logic                                                              recv_valid_i,
  input  logic [acc_disp_pkg::TRANS_ID_BITS-1:0]                            recv_trans_id_i,
  input  logic [acc_disp_pkg::NR_COMMIT_PORTS-1:0]                          commit_issued_i,
  input  acc_disp_pkg::fu_e [acc_disp_pkg::NR_COMMIT_PORTS-1:0]             commit_fu_i,
  input  logic [acc_disp_pkg::NR_COMMIT_PORTS-1:0][acc_disp_pkg::TRANS_ID_BITS-1:0]
                                                                            commit_trans_id_i,
  input  logic                                                              dispatch_i,
  input  logic [acc_disp_pkg::TRANS_ID_BITS-1:0]                            dispatch_trans_id_i,
  input  logic [acc_disp_pkg::TRANS_ID_BITS-1:0]                            query_trans_id_i,
  output logic                                                              query_ok_o
);

  logic [acc_disp_pkg::NR_SB_ENTRIES-1:0] pending_d, pending_q;
  logic [acc_disp_pkg::NR_SB_ENTRIES-1:0] ready_d, ready_q;
  logic                                   release_v;
  logic                                   release_ok;
  logic [acc_disp_pkg::TRANS_ID_BITS-1:0] release_id;

  // First unissued commit entry, port 1 only behind an issued port 0
  always_comb begin
    release_v = 1'b0;
    if (!commit_issued_i[0] && commit_fu_i[0] == acc_disp_pkg::ACCEL)
      release_v = 1'b1;
    if (commit_issued_i[0] && !commit_issued_i[1] && commit_fu_i[1] == acc_disp_pkg::ACCEL)
      release_v = 1'b1;
  end

  assign release_id = commit_issued_i[0] ? commit_trans_id_i[1] : commit_trans_id_i[0];

  // Also catch an ID that arrives in the release cycle itself
  assign release_ok = release_v &&
                      (pending_q[release_id] ||
                       (recv_valid_i && recv_trans_id_i == release_id));

  always_comb begin
    pending_d = pending_q;
    ready_d   = ready_q;
    if (recv_valid_i)
      pending_d[recv_trans_id_i] = 1'b1;
    // No longer speculative
    if (release_ok) begin
      pending_d[release_id] = 1'b0;
      ready_d[release_id]   = 1'b1;
    end
    // Sent to the request register
    if (dispatch_i)
      ready_d[dispatch_trans_id_i] = 1'b0;
    // Ready IDs survive a flush
    if (flush_i)
      pending_d = '0;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= '0;
      ready_q   <= '0;
    end else begin
      pending_q <= pending_d;
      ready_q   <= ready_d;
    end
  end

  assign query_ok_o = ready_q[query_trans_id_i] ||
                      (release_ok && release_id == query_trans_id_i);

endmodule
